/* source/soc_bus_defines.svh */
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// Scratch RAM window, top is exclusive
`define RAM_BASE 32'h0000_0000
`define RAM_TOP  32'h0000_1000

// CLINT window
`define CLINT_BASE 32'h0200_0000
`define CLINT_TOP  32'h0201_0000

// Depth in 32-bit words, follows the window size
`define RAM_WORDS ((`RAM_TOP - `RAM_BASE) / 4)

// CLINT register offsets from the window base
`define CLINT_MSIP        32'h0000_0000
`define CLINT_MTIMECMP_LO 32'h0000_4000
`define CLINT_MTIMECMP_HI 32'h0000_4004
`define CLINT_MTIME_LO    32'h0000_BFF8
`define CLINT_MTIME_HI    32'h0000_BFFC

`endif

/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // All zero for a read
  typedef logic [63:0] mtime_t;

  // Master request, valid is a one-cycle pulse
  typedef struct packed {
    logic  valid;
    logic  instr;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } bus_req_t;

  // Target answer
  typedef struct packed {
    logic  ready;
    data_t rdata;
  } slave_rsp_t;

  // Combined answer to the master
  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* source/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module bus_decoder (
  input  soc_bus_pkg::bus_req_t req,
  output soc_bus_pkg::bus_req_t ram_req,
  output soc_bus_pkg::bus_req_t clint_req,
  output logic                  unmapped
);

  logic in_ram;
  logic in_clint;

  // Window hits, independent of valid
  assign in_ram   = (req.addr >= `RAM_BASE) && (req.addr < `RAM_TOP);
  assign in_clint = (req.addr >= `CLINT_BASE) && (req.addr < `CLINT_TOP);

  always_comb begin
    ram_req.valid = 1'b0;
    clint_req.valid = 1'b0;
    unmapped = 1'b0;

    if (req.valid) begin
      if (in_ram) begin
        ram_req.valid = 1'b1;
      end else if (in_clint) begin
        clint_req.valid = 1'b1;
      end else begin
        unmapped = 1'b1;  // Old ROM, UART and AXI windows land here too
      end
    end
  end

  // Payload goes to both targets, only the valid strobe is steered
  always_comb begin
    ram_req.instr = req.instr;
    ram_req.wdata = req.wdata;
    ram_req.wstrb = req.wstrb;
    ram_req.addr  = req.addr - `RAM_BASE;

    clint_req.instr = req.instr;
    clint_req.wdata = req.wdata;
    clint_req.wstrb = req.wstrb;
    clint_req.addr  = req.addr - `CLINT_BASE;  // Offset within the CLINT
  end

endmodule

`default_nettype wire

/* source/scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module scratch_ram (
  input  logic                    clock,
  input  logic                    reset,
  input  soc_bus_pkg::bus_req_t   req,
  output soc_bus_pkg::slave_rsp_t rsp
);

  localparam int INDEX_BITS = $clog2(`RAM_WORDS);

  soc_bus_pkg::data_t    mem [`RAM_WORDS];
  logic [INDEX_BITS-1:0] index;
  logic                  write;
  logic                  ready_q;
  soc_bus_pkg::data_t    rdata_q;

  assign index = req.addr[INDEX_BITS+1:2];  // Word part of the offset
  assign write = req.valid && (req.wstrb != '0);

  // Strobed byte lanes only
  always_ff @(posedge clock) begin
    if (write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Old word is returned, also on a write
  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata_q <= mem[index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req.valid;
    end
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* source/timer_clint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module timer_clint (
  input  logic                    clock,
  input  logic                    reset,
  input  soc_bus_pkg::bus_req_t   req,
  output soc_bus_pkg::slave_rsp_t rsp,
  output logic                    msip,
  output logic                    mtip,
  output soc_bus_pkg::mtime_t     mtime
);

  logic                sel_msip;
  logic                sel_cmp_lo;
  logic                sel_cmp_hi;
  logic                sel_time_lo;
  logic                sel_time_hi;
  logic                write;
  logic                msip_q;
  logic                mtip_q;
  logic                ready_q;
  soc_bus_pkg::mtime_t mtimecmp_q;
  soc_bus_pkg::mtime_t mtime_q;
  soc_bus_pkg::mtime_t mtime_next;
  soc_bus_pkg::data_t  read_data;
  soc_bus_pkg::data_t  rdata_q;

  function automatic soc_bus_pkg::data_t merge(input soc_bus_pkg::data_t old_word,
                                               input soc_bus_pkg::data_t new_word,
                                               input soc_bus_pkg::strb_t strb);
    soc_bus_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign sel_msip    = (req.addr == `CLINT_MSIP);
  assign sel_cmp_lo  = (req.addr == `CLINT_MTIMECMP_LO);
  assign sel_cmp_hi  = (req.addr == `CLINT_MTIMECMP_HI);
  assign sel_time_lo = (req.addr == `CLINT_MTIME_LO);
  assign sel_time_hi = (req.addr == `CLINT_MTIME_HI);
  assign write       = req.valid && (req.wstrb != '0);

  // Free-running count, a write replaces the strobed bytes
  always_comb begin
    mtime_next = mtime_q + 64'd1;
    if (write && sel_time_lo) begin
      mtime_next[31:0] = merge(mtime_next[31:0], req.wdata, req.wstrb);
    end
    if (write && sel_time_hi) begin
      mtime_next[63:32] = merge(mtime_next[63:32], req.wdata, req.wstrb);
    end
  end

  always_comb begin
    read_data = '0;  // Unlisted offsets read as zero
    if (sel_msip) begin
      read_data = {31'b0, msip_q};
    end else if (sel_cmp_lo) begin
      read_data = mtimecmp_q[31:0];
    end else if (sel_cmp_hi) begin
      read_data = mtimecmp_q[63:32];
    end else if (sel_time_lo) begin
      read_data = mtime_q[31:0];
    end else if (sel_time_hi) begin
      read_data = mtime_q[63:32];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q    <= 1'b0;
      msip_q     <= 1'b0;
      mtip_q     <= 1'b0;
      mtimecmp_q <= '1;  // No timer interrupt until software sets a compare
      mtime_q    <= '0;
    end else begin
      ready_q <= req.valid;
      mtime_q <= mtime_next;
      mtip_q  <= (mtime_q >= mtimecmp_q);
      if (write && sel_msip && req.wstrb[0]) begin
        msip_q <= req.wdata[0];
      end
      if (write && sel_cmp_lo) begin
        mtimecmp_q[31:0] <= merge(mtimecmp_q[31:0], req.wdata, req.wstrb);
      end
      if (write && sel_cmp_hi) begin
        mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], req.wdata, req.wstrb);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata_q <= read_data;
    end
  end

  assign rsp   = '{ready: ready_q, rdata: rdata_q};
  assign msip  = msip_q;
  assign mtip  = mtip_q;
  assign mtime = mtime_q;

endmodule

`default_nettype wire

/* source/response_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module response_mux (
  input  logic                    clock,
  input  logic                    reset,
  input  soc_bus_pkg::slave_rsp_t ram_rsp,
  input  soc_bus_pkg::slave_rsp_t clint_rsp,
  input  logic                    unmapped,
  output soc_bus_pkg::bus_rsp_t   rsp
);

  logic               error_q;
  soc_bus_pkg::data_t ram_data;
  soc_bus_pkg::data_t clint_data;

  // Error responder, answers one cycle after an unmapped request
  always_ff @(posedge clock) begin
    if (!reset) begin
      error_q <= 1'b0;
    end else begin
      error_q <= unmapped;
    end
  end

  // Only one target can be ready, so the data is AND-OR merged
  assign ram_data   = ram_rsp.ready ? ram_rsp.rdata : '0;
  assign clint_data = clint_rsp.ready ? clint_rsp.rdata : '0;

  always_comb begin
    rsp.ready = ram_rsp.ready | clint_rsp.ready | error_q;
    rsp.error = error_q;
    if (error_q) begin
      rsp.rdata = '0;  // Error carries no data
    end else begin
      rsp.rdata = ram_data | clint_data;
    end
  end

endmodule

`default_nettype wire

/* source/soc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::bus_req_t req,
  output soc_bus_pkg::bus_rsp_t rsp,
  output logic                  msip,
  output logic                  mtip,
  output soc_bus_pkg::mtime_t   mtime
);

  soc_bus_pkg::bus_req_t   ram_req;
  soc_bus_pkg::bus_req_t   clint_req;
  soc_bus_pkg::slave_rsp_t ram_rsp;
  soc_bus_pkg::slave_rsp_t clint_rsp;
  logic                    unmapped;

  bus_decoder decoder0 (
    .req       (req),
    .ram_req   (ram_req),
    .clint_req (clint_req),
    .unmapped  (unmapped)
  );

  scratch_ram ram0 (
    .clock (clock),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  // Timer and software interrupt levels go straight out
  timer_clint clint0 (
    .clock (clock),
    .reset (reset),
    .req   (clint_req),
    .rsp   (clint_rsp),
    .msip  (msip),
    .mtip  (mtip),
    .mtime (mtime)
  );

  response_mux combiner0 (
    .clock     (clock),
    .reset     (reset),
    .ram_rsp   (ram_rsp),
    .clint_rsp (clint_rsp),
    .unmapped  (unmapped),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* tb/soc_bus_props.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_props (
  input logic                  clock,
  input logic                  reset,
  input soc_bus_pkg::bus_req_t req,
  input soc_bus_pkg::bus_rsp_t rsp
);

  // Every request pulse is answered on the next clock
  ready_after_valid: assert property (
    @(posedge clock) disable iff (!reset) req.valid |=> rsp.ready
  ) else $error("ready did not follow valid after one cycle");

  ready_needs_valid: assert property (
    @(posedge clock) disable iff (!reset) rsp.ready |-> $past(req.valid)
  ) else $error("ready without a valid in the cycle before");

  // Error response carries no data
  error_is_response: assert property (
    @(posedge clock) rsp.error |-> (rsp.ready && (rsp.rdata == '0))
  ) else $error("error without ready or with nonzero rdata");

  quiet_in_reset: assert property (
    @(posedge clock) !reset |=> (!rsp.ready && !rsp.error)
  ) else $error("ready or error high during reset");

endmodule

`default_nettype wire

/* tb/soc_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module soc_bus_tb;

  localparam int INDEX_BITS     = $clog2(`RAM_WORDS);
  localparam int RAM_PAIRS      = 64;
  localparam int ACCESS_COUNT   = `RAM_WORDS + 2 * RAM_PAIRS + 11 + 4 + 4 + 7;
  localparam int TIMEOUT_CYCLES = ACCESS_COUNT * 3 + 200;

  typedef struct packed {
    soc_bus_pkg::data_t data;
    logic               error;
    logic               known;  // False where rdata cannot be predicted
  } expect_t;

  logic                  clock;
  logic                  reset;
  soc_bus_pkg::bus_req_t req;
  soc_bus_pkg::bus_rsp_t rsp;
  logic                  msip;
  logic                  mtip;
  soc_bus_pkg::mtime_t   mtime;

  soc_bus_pkg::data_t  shadow_ram [`RAM_WORDS];
  logic                shadow_init [`RAM_WORDS];
  logic                shadow_msip;
  soc_bus_pkg::mtime_t shadow_cmp;
  expect_t             expect_q [$];
  logic [31:0]         lfsr_state;
  soc_bus_pkg::data_t  last_rdata;
  int                  errors;
  int                  checks;
  int                  test_errors;
  int                  test_checks;
  int                  accesses;
  int                  cycles;
  int                  drive_cycle;

  soc_bus dut0 (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .rsp   (rsp),
    .msip  (msip),
    .mtip  (mtip),
    .mtime (mtime)
  );

  bind soc_bus soc_bus_props props0 (.clock(clock), .reset(reset), .req(req), .rsp(rsp));

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic soc_bus_pkg::data_t fill_word(input soc_bus_pkg::addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic soc_bus_pkg::data_t merge_bytes(input soc_bus_pkg::data_t old_word,
                                                     input soc_bus_pkg::data_t new_word,
                                                     input soc_bus_pkg::strb_t strb);
    soc_bus_pkg::data_t result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = strb[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
    end
    return result;
  endfunction

  function automatic expect_t ref_read(input soc_bus_pkg::bus_req_t request);
    expect_t            result;
    int                 index;
    soc_bus_pkg::addr_t offset;
    result = '{data: '0, error: 1'b0, known: 1'b1};
    if (request.addr >= `RAM_BASE && request.addr < `RAM_TOP) begin
      index = int'((request.addr - `RAM_BASE) >> 2);
      result.data = shadow_ram[index];
      result.known = shadow_init[index];
    end else if (request.addr >= `CLINT_BASE && request.addr < `CLINT_TOP) begin
      offset = request.addr - `CLINT_BASE;
      case (offset)
        `CLINT_MSIP:        result.data = {31'b0, shadow_msip};
        `CLINT_MTIMECMP_LO: result.data = shadow_cmp[31:0];
        `CLINT_MTIMECMP_HI: result.data = shadow_cmp[63:32];
        `CLINT_MTIME_LO,
        `CLINT_MTIME_HI:    result.known = 1'b0;  // Counter runs on its own
        default:            result.data = '0;
      endcase
    end else begin
      result.error = 1'b1;
    end
    return result;
  endfunction

  function automatic void update_shadow(input soc_bus_pkg::bus_req_t request);
    int                 index;
    soc_bus_pkg::addr_t offset;
    offset = request.addr - `CLINT_BASE;
    if (request.wstrb != '0) begin
      if (request.addr >= `RAM_BASE && request.addr < `RAM_TOP) begin
        index = int'((request.addr - `RAM_BASE) >> 2);
        shadow_ram[index] = merge_bytes(shadow_ram[index], request.wdata, request.wstrb);
        if (request.wstrb == 4'hf) begin
          shadow_init[index] = 1'b1;
        end
      end else if (request.addr >= `CLINT_BASE && request.addr < `CLINT_TOP) begin
        if (offset == `CLINT_MSIP && request.wstrb[0]) begin
          shadow_msip = request.wdata[0];
        end
        if (offset == `CLINT_MTIMECMP_LO) begin
          shadow_cmp[31:0] = merge_bytes(shadow_cmp[31:0], request.wdata, request.wstrb);
        end
        if (offset == `CLINT_MTIMECMP_HI) begin
          shadow_cmp[63:32] = merge_bytes(shadow_cmp[63:32], request.wdata, request.wstrb);
        end
      end
    end
  endfunction

  task automatic check_data(input string what, input soc_bus_pkg::data_t got,
                            input soc_bus_pkg::data_t want);
    checks++;
    test_checks++;
    if (got !== want) begin
      $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_error(input string what, input logic got, input logic want);
    checks++;
    test_checks++;
    if (got !== want) begin
      $display("ERROR %0t: %s flag is %b, expected %b", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic want);
    checks++;
    test_checks++;
    if (got !== want) begin
      $display("ERROR %0t: %s level is %b, expected %b", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_time(input string what, input soc_bus_pkg::mtime_t got,
                            input soc_bus_pkg::mtime_t want);
    checks++;
    test_checks++;
    if (got !== want) begin
      $display("ERROR %0t: %s is 0x%016h, expected 0x%016h", $time, what, got, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d checks and %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // One request, then wait until the compare process has taken its answer
  task automatic access(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
                        input soc_bus_pkg::strb_t wstrb);
    soc_bus_pkg::bus_req_t request;
    request = '{valid: 1'b1, instr: 1'b0, addr: addr, wdata: wdata, wstrb: wstrb};
    @(negedge clock);
    expect_q.push_back(ref_read(request));
    update_shadow(request);
    req = request;
    drive_cycle = cycles;
    accesses++;
    @(negedge clock);
    req.valid = 1'b0;
    while (expect_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // Response is registered, so it is steady at the falling edge
  always @(negedge clock) begin
    expect_t want;
    if (reset && rsp.ready) begin
      if (expect_q.size() == 0) begin
        $display("ERROR %0t: ready response with no request outstanding", $time);
        errors++;
      end else begin
        want = expect_q.pop_front();
        check_error("response error", rsp.error, want.error);
        if (want.known) begin
          check_data("read data", rsp.rdata, want.data);
        end
        last_rdata = rsp.rdata;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d request(s) never got a ready response",
             cycles, expect_q.size());
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0]        bits;
    soc_bus_pkg::addr_t addr;
    soc_bus_pkg::data_t wdata;
    soc_bus_pkg::data_t first;
    soc_bus_pkg::data_t second;
    soc_bus_pkg::addr_t holes [8];
    reset = 1'b0;
    req = '0;
    lfsr_state = 32'h3ab4_cf34;
    errors = 0;
    checks = 0;
    test_errors = 0;
    test_checks = 0;
    accesses = 0;
    drive_cycle = 0;
    shadow_msip = 1'b0;
    shadow_cmp = '1;
    for (int i = 0; i < `RAM_WORDS; i++) begin
      shadow_init[i] = 1'b0;
    end
    holes = '{32'h0000_1000, 32'h0001_0000, 32'h0201_0000, 32'h0280_0000,
              32'h1000_0000, 32'h4000_0000, 32'h8000_0000, 32'hffff_fffc};
    repeat (3) @(negedge clock);
    reset = 1'b1;

    for (int i = 0; i < `RAM_WORDS; i++) begin
      addr = `RAM_BASE + 4 * i;
      access(addr, fill_word(addr), 4'hf);
    end
    end_test("ram_fill");

    for (int n = 0; n < RAM_PAIRS; n++) begin
      draw_bits(INDEX_BITS, bits);
      addr = `RAM_BASE + (bits << 2);
      draw_bits(32, wdata);
      draw_bits(4, bits);
      access(addr, wdata, soc_bus_pkg::strb_t'(bits));
      access(addr, '0, '0);
    end
    end_test("ram_write_read");

    for (int i = 0; i < 8; i++) begin
      access(holes[i], fill_word(holes[i]), (i % 2 == 0) ? 4'h0 : 4'hf);
    end
    access(`RAM_BASE, '0, '0);  // Nothing above may have leaked into a target
    access(`RAM_TOP - 4, '0, '0);
    access(`CLINT_BASE + `CLINT_MSIP, '0, '0);
    end_test("unmapped");

    access(`CLINT_BASE + `CLINT_MSIP, 32'h1, 4'hf);
    check_level("msip", msip, 1'b1);
    access(`CLINT_BASE + `CLINT_MSIP, '0, '0);
    access(`CLINT_BASE + `CLINT_MSIP, 32'h0, 4'hf);
    check_level("msip", msip, 1'b0);
    access(`CLINT_BASE + `CLINT_MSIP, '0, '0);
    end_test("msip");

    check_level("mtip after reset", mtip, 1'b0);
    draw_bits(32, wdata);
    access(`CLINT_BASE + `CLINT_MTIMECMP_LO, wdata, 4'hf);
    draw_bits(32, wdata);
    access(`CLINT_BASE + `CLINT_MTIMECMP_HI, wdata | 32'h8000_0000, 4'hf);
    access(`CLINT_BASE + `CLINT_MTIMECMP_LO, '0, '0);
    access(`CLINT_BASE + `CLINT_MTIMECMP_HI, '0, '0);
    end_test("mtimecmp");

    access(`CLINT_BASE + `CLINT_MTIMECMP_HI, 32'h1, 4'hf);
    access(`CLINT_BASE + `CLINT_MTIMECMP_LO, 32'h0, 4'hf);
    access(`CLINT_BASE + `CLINT_MTIME_HI, 32'h0, 4'hf);
    access(`CLINT_BASE + `CLINT_MTIME_LO, 32'hffff_ff00, 4'hf);  // Just below the compare
    repeat (4) @(negedge clock);
    check_level("mtip below compare", mtip, 1'b0);
    // One count per clock since the edge that took the write
    check_time("mtime", mtime,
               64'h0000_0000_ffff_ff00 + soc_bus_pkg::mtime_t'(cycles - drive_cycle - 1));
    access(`CLINT_BASE + `CLINT_MTIMECMP_HI, 32'h0, 4'hf);
    repeat (2) @(negedge clock);
    check_level("mtip past compare", mtip, 1'b1);
    access(`CLINT_BASE + `CLINT_MTIME_LO, '0, '0);
    first = last_rdata;
    access(`CLINT_BASE + `CLINT_MTIME_LO, '0, '0);
    second = last_rdata;
    check_level("mtime non-decreasing", second >= first, 1'b1);
    end_test("mtip");

    if (expect_q.size() != 0) begin
      $display("Run ended with %0d request(s) still waiting for ready", expect_q.size());
      errors++;
    end
    $display("Accesses %0d, checks %0d, errors %0d", accesses, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_bus.f */
+incdir+source
source/soc_bus_pkg.sv
source/bus_decoder.sv
source/scratch_ram.sv
source/timer_clint.sv
source/response_mux.sv
source/soc_bus.sv
tb/soc_bus_props.sv
tb/soc_bus_tb.sv

/* Bender.yml */
package:
  name: soc_bus

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/soc_bus_pkg.sv
      - source/bus_decoder.sv
      - source/scratch_ram.sv
      - source/timer_clint.sv
      - source/response_mux.sv
      - source/soc_bus.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/soc_bus_props.sv
      - tb/soc_bus_tb.sv
